//--- all.f
rtl/radio_ctrl_pkg.sv
rtl/tick_gen.sv
rtl/debounce.sv
rtl/tx_keying.sv
rtl/fan_ctrl.sv
rtl/cmd_resp_fsm.sv
rtl/resp_mux.sv
rtl/radio_ctrl.sv
bench/tb_clk_gen.sv
bench/radio_ctrl_tb.sv

//--- Makefile
TOP := radio_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module radio_ctrl

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- bench/radio_ctrl_tb.sv
`timescale 1ns/1ns

module radio_ctrl_tb;

  localparam logic [7:0] VERSION = 8'h48;
  // Roughly ten times the 600 cycles that all tests take together
  localparam int WATCHDOG_CYCLES = 6000;

  logic                              clk;
  logic                              slow_adc_rst;
  radio_ctrl_pkg::cmd_t              cmd_i;
  radio_ctrl_pkg::sub_resp_t         sub_resp_i;
  radio_ctrl_pkg::adc_readings_t     adc_i;
  logic                              tx_on_i;
  logic                              run_i;
  logic                              ptt_n_i;
  logic                              tx_inhibit_n_i;
  logic                              rxclip_i;
  logic [7:0]                        dsiq_status_i;
  logic                              resp_rqst_i;
  logic [radio_ctrl_pkg::RESP_W-1:0] resp_o;
  logic                              dsiq_sample_o;
  radio_ctrl_pkg::pa_ctrl_t          pa_o;
  logic                              fan_pwm_o;
  logic                              qmsec_pulse_o;
  logic                              msec_pulse_o;

  // Bench view of DUT state
  logic        vna_q;
  logic        pa_en_q;
  logic        tr_dis_q;
  logic [1:0]  slot_q;
  logic        parity_q;
  logic        dsiq_q;
  logic        ptt_flag;
  logic        pend_q;
  logic [5:0]  pend_addr;
  logic [31:0] pend_data;

  tb_clk_gen i_clk_gen (
    .clk_o         (clk),
    .slow_adc_rst_o(slow_adc_rst)
  );

  radio_ctrl #(
    .VERSION_MAJOR  (VERSION),
    .QMSEC_RELOAD   (9),
    .DEBOUNCE_CYCLES(4),
    .FAN_CNT_W      (4)
  ) i_dut (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .cmd_i         (cmd_i),
    .sub_resp_i    (sub_resp_i),
    .adc_i         (adc_i),
    .tx_on_i       (tx_on_i),
    .run_i         (run_i),
    .ptt_n_i       (ptt_n_i),
    .tx_inhibit_n_i(tx_inhibit_n_i),
    .rxclip_i      (rxclip_i),
    .dsiq_status_i (dsiq_status_i),
    .resp_rqst_i   (resp_rqst_i),
    .resp_o        (resp_o),
    .dsiq_sample_o (dsiq_sample_o),
    .pa_o          (pa_o),
    .fan_pwm_o     (fan_pwm_o),
    .qmsec_pulse_o (qmsec_pulse_o),
    .msec_pulse_o  (msec_pulse_o)
  );

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_resp(input string name, input logic [radio_ctrl_pkg::RESP_W-1:0] exp_val,
                            input logic [radio_ctrl_pkg::RESP_W-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_pa(input string name, input radio_ctrl_pkg::pa_ctrl_t exp_val,
                          input radio_ctrl_pkg::pa_ctrl_t act_val);
    if (act_val !== exp_val) begin
      $display("[FAIL] %s expected %b actual %b", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("[FAIL] %s expected %b actual %b", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_duty(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // Keying rules applied to the bench copy of the control register
  function automatic radio_ctrl_pkg::pa_ctrl_t expected_pa(input logic active);
    radio_ctrl_pkg::pa_ctrl_t pa;
    pa.envop    = active;
    pa.exttr    = active;
    pa.envbias  = active & ~vna_q & pa_en_q;
    pa.envpa    = active & ~vna_q & pa_en_q;
    pa.inttr    = active & ~vna_q & (pa_en_q | ~tr_dis_q);
    pa.rfsw_sel = ~vna_q & pa_en_q;
    return pa;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Returns on the rising edge that captures the command
  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data, input logic needs_resp);
    radio_ctrl_pkg::cmd_t c;
    c.addr          = addr;
    c.data          = data;
    c.rqst          = 1'b1;
    c.requires_resp = needs_resp;
    @(posedge clk);
    cmd_i <= c;
    @(posedge clk);
    cmd_i <= '0;
  endtask

  task automatic write_tx_ctrl(input logic [31:0] data);
    send_cmd(radio_ctrl_pkg::CMD_TX_CTRL, data, 1'b0);
    vna_q    = data[23];
    pa_en_q  = data[19];
    tr_dis_q = data[18];
  endtask

  task automatic issue_request(input string name, input int clip_cycles);
    logic [radio_ctrl_pkg::RESP_W-1:0] exp_word;
    logic [31:0]                       payload;
    repeat (clip_cycles) begin
      @(posedge clk);
      rxclip_i <= 1'b1;
    end
    @(posedge clk);
    rxclip_i <= 1'b0;
    @(posedge clk);
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    resp_rqst_i <= 1'b0;
    case (slot_q)
      2'd0: payload = {7'h0F, clip_cycles >= 3, 8'h00, dsiq_status_i, VERSION};
      2'd1: payload = {4'h0, adc_i.temperature, 4'h0, adc_i.fwd_pwr};
      2'd2: payload = {4'h0, adc_i.rev_pwr, 4'h0, adc_i.bias_current};
      default: payload = 32'h0;
    endcase
    if (pend_q && !parity_q) begin
      exp_word = {1'b1, pend_addr, ptt_flag, pend_data};
      pend_q   = 1'b0;
    end else begin
      exp_word = {3'b000, slot_q, 2'b00, ptt_flag, payload};
    end
    if (slot_q == 2'd1) begin
      dsiq_q = ~dsiq_q;
    end
    slot_q   = slot_q + 2'd1;
    parity_q = ~parity_q;
    @(negedge clk);
    check_resp(name, exp_word, resp_o);
    check_bit({name, " dsiq sample"}, dsiq_q, dsiq_sample_o);
    wait_cycles(3);
  endtask

  task automatic test_timebase();
    for (int n = 1; n <= 80; n++) begin
      @(negedge clk);
      if (n == 1) begin
        check_resp("idle word", {8'h00, 8'h1E, 16'h0000, VERSION}, resp_o);
        check_pa("reset pa", '0, pa_o);
      end
      check_bit("qmsec pulse", (n % 10) == 0, qmsec_pulse_o);
      check_bit("msec pulse", (n % 40) == 0, msec_pulse_o);
    end
  endtask

  task automatic test_keying();
    @(posedge clk);
    tx_on_i <= 1'b1;
    run_i   <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      write_tx_ctrl($urandom);
      @(negedge clk);
      check_pa("keying", expected_pa(1'b1), pa_o);
    end
    @(posedge clk);
    tx_inhibit_n_i <= 1'b0;
    wait_cycles(6);
    @(negedge clk);
    check_pa("tx inhibit", expected_pa(1'b0), pa_o);
    @(posedge clk);
    tx_inhibit_n_i <= 1'b1;
    tx_on_i        <= 1'b0;
    ptt_n_i        <= 1'b0;
    wait_cycles(6);
    @(negedge clk);
    check_pa("ptt keying", expected_pa(1'b1), pa_o);
    @(posedge clk);
    ptt_n_i <= 1'b1;
    wait_cycles(6);
    @(negedge clk);
    check_pa("ptt released", expected_pa(1'b0), pa_o);
  endtask

  task automatic fan_step(input string name, input logic [11:0] temp, input int exp_high,
                          input logic exp_tx);
    int high_cnt;
    @(posedge clk);
    adc_i.temperature <= temp;
    wait_cycles(4);
    high_cnt = 0;
    repeat (16) begin
      @(negedge clk);
      if (fan_pwm_o) begin
        high_cnt++;
      end
    end
    check_duty({name, " duty"}, exp_high, high_cnt);
    check_pa({name, " keying"}, expected_pa(exp_tx), pa_o);
  endtask

  task automatic test_fan();
    // PA enabled with VNA off
    write_tx_ctrl(32'h0008_0000);
    @(posedge clk);
    tx_on_i <= 1'b1;
    fan_step("fan off", radio_ctrl_pkg::TEMP_30C - 12'd1, 0, 1'b1);
    fan_step("fan low", radio_ctrl_pkg::TEMP_35C + 12'd1, 8, 1'b1);
    fan_step("fan med", radio_ctrl_pkg::TEMP_40C + 12'd1, 12, 1'b1);
    fan_step("fan full", radio_ctrl_pkg::TEMP_45C + 12'd1, 16, 1'b1);
    fan_step("fan overheat", radio_ctrl_pkg::TEMP_55C + 12'd1, 16, 1'b0);
    fan_step("fan cooled", radio_ctrl_pkg::TEMP_50C - 12'd1, 16, 1'b1);
    fan_step("fan back med", radio_ctrl_pkg::TEMP_40C - 12'd1, 12, 1'b1);
    fan_step("fan back low", radio_ctrl_pkg::TEMP_35C - 12'd1, 8, 1'b1);
    fan_step("fan back off", radio_ctrl_pkg::TEMP_30C - 12'd1, 0, 1'b1);
  endtask

  task automatic test_status_slots();
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      adc_i.fwd_pwr      <= 12'($urandom);
      adc_i.rev_pwr      <= 12'($urandom);
      adc_i.bias_current <= 12'($urandom);
      adc_i.temperature  <= 12'($urandom);
      dsiq_status_i      <= 8'($urandom);
      // Front-panel PTT held for the second half
      if (i == 8) begin
        ptt_n_i <= 1'b0;
        wait_cycles(6);
        ptt_flag = 1'b1;
      end
      // Slot 0 requests see 0, 4, 3 and 2 clip cycles
      issue_request("status slot", i % 5);
    end
    @(posedge clk);
    ptt_n_i <= 1'b1;
    wait_cycles(6);
    ptt_flag = 1'b0;
  endtask

  task automatic test_cmd_echo();
    pend_addr = 6'h20 + 6'($urandom % 31);
    pend_data = $urandom;
    send_cmd(pend_addr, pend_data, 1'b1);
    pend_q = 1'b1;
    wait_cycles(8);
    while (pend_q) begin
      issue_request("command echo", 0);
    end
  endtask

  task automatic test_cmd_read();
    pend_addr = 6'h20 + 6'($urandom % 31);
    send_cmd(pend_addr, $urandom, 1'b1);
    @(posedge clk);
    // Subsystem busy for five cycles of read data
    for (int i = 0; i < 5; i++) begin
      pend_data = $urandom;
      sub_resp_i.ack   <= 1'b0;
      sub_resp_i.rdata <= pend_data;
      @(posedge clk);
    end
    sub_resp_i.ack <= 1'b1;
    pend_q = 1'b1;
    wait_cycles(4);
    while (pend_q) begin
      issue_request("command read", 0);
    end
  endtask

  task automatic test_cmd_error();
    pend_data = $urandom;
    send_cmd(6'h20 + 6'($urandom % 31), pend_data, 1'b1);
    sub_resp_i.ack <= 1'b0;
    @(posedge clk);
    sub_resp_i.ack <= 1'b1;
    pend_addr = radio_ctrl_pkg::CMD_ERROR;
    pend_q    = 1'b1;
    wait_cycles(4);
    while (pend_q) begin
      issue_request("command error", 0);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    void'($urandom(16914));
    cmd_i            = '0;
    sub_resp_i.ack   = 1'b1;
    sub_resp_i.rdata = 32'h0;
    adc_i            = '0;
    tx_on_i          = 1'b0;
    run_i            = 1'b0;
    ptt_n_i          = 1'b1;
    tx_inhibit_n_i   = 1'b1;
    rxclip_i         = 1'b0;
    dsiq_status_i    = 8'h00;
    resp_rqst_i      = 1'b0;
    vna_q            = 1'b0;
    pa_en_q          = 1'b0;
    tr_dis_q         = 1'b0;
    slot_q           = 2'd0;
    parity_q         = 1'b0;
    dsiq_q           = 1'b0;
    ptt_flag         = 1'b0;
    pend_q           = 1'b0;
    @(negedge slow_adc_rst);
    @(posedge clk);
    test_timebase();
    test_keying();
    test_fan();
    test_status_slots();
    test_cmd_echo();
    test_cmd_read();
    test_cmd_error();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic slow_adc_rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset seen by the first RESET_CYCLES rising edges
  initial begin
    slow_adc_rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    slow_adc_rst_o <= 1'b0;
  end

endmodule

//--- rtl/radio_ctrl.sv
`timescale 1ns/1ns

module radio_ctrl #(
  parameter logic [7:0] VERSION_MAJOR   = 8'h00,
  parameter int         QMSEC_RELOAD    = 625,
  parameter int         DEBOUNCE_CYCLES = 16250,
  parameter int         FAN_CNT_W       = 16
) (
  input  logic                              clk,
  input  logic                              slow_adc_rst,
  input  radio_ctrl_pkg::cmd_t              cmd_i,
  input  radio_ctrl_pkg::sub_resp_t         sub_resp_i,
  input  radio_ctrl_pkg::adc_readings_t     adc_i,
  input  logic                              tx_on_i,
  input  logic                              run_i,
  input  logic                              ptt_n_i,
  input  logic                              tx_inhibit_n_i,
  input  logic                              rxclip_i,
  input  logic [7:0]                        dsiq_status_i,
  input  logic                              resp_rqst_i,
  output logic [radio_ctrl_pkg::RESP_W-1:0] resp_o,
  output logic                              dsiq_sample_o,
  output radio_ctrl_pkg::pa_ctrl_t          pa_o,
  output logic                              fan_pwm_o,
  output logic                              qmsec_pulse_o,
  output logic                              msec_pulse_o
);

  logic                      ptt_db;
  logic                      inhibit_db;
  logic                      temp_tx_enable;
  logic                      resp_taken;
  radio_ctrl_pkg::cmd_resp_t pending;

  tick_gen #(
    .QMSEC_RELOAD(QMSEC_RELOAD)
  ) i_tick_gen (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .qmsec_pulse_o(qmsec_pulse_o),
    .msec_pulse_o (msec_pulse_o)
  );

  debounce #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) i_debounce_ptt (
    .clk         (clk),
    .slow_adc_rst(slow_adc_rst),
    .pin_n_i     (ptt_n_i),
    .level_o     (ptt_db)
  );

  debounce #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) i_debounce_inhibit (
    .clk         (clk),
    .slow_adc_rst(slow_adc_rst),
    .pin_n_i     (tx_inhibit_n_i),
    .level_o     (inhibit_db)
  );

  tx_keying i_tx_keying (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .cmd_i           (cmd_i),
    .tx_on_i         (tx_on_i),
    .run_i           (run_i),
    .ptt_i           (ptt_db),
    .inhibit_i       (inhibit_db),
    .temp_tx_enable_i(temp_tx_enable),
    .pa_o            (pa_o)
  );

  fan_ctrl #(
    .FAN_CNT_W(FAN_CNT_W)
  ) i_fan_ctrl (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .temperature_i(adc_i.temperature),
    .fan_pwm_o    (fan_pwm_o),
    .tx_enable_o  (temp_tx_enable)
  );

  cmd_resp_fsm i_cmd_resp_fsm (
    .clk         (clk),
    .slow_adc_rst(slow_adc_rst),
    .cmd_i       (cmd_i),
    .sub_resp_i  (sub_resp_i),
    .taken_i     (resp_taken),
    .pending_o   (pending)
  );

  resp_mux #(
    .VERSION_MAJOR(VERSION_MAJOR)
  ) i_resp_mux (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .resp_rqst_i  (resp_rqst_i),
    .pending_i    (pending),
    .taken_o      (resp_taken),
    .adc_i        (adc_i),
    .ptt_i        (ptt_db),
    .rxclip_i     (rxclip_i),
    .dsiq_status_i(dsiq_status_i),
    .resp_o       (resp_o),
    .dsiq_sample_o(dsiq_sample_o)
  );

endmodule

//--- rtl/resp_mux.sv
`timescale 1ns/1ns

module resp_mux #(
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  logic                              clk,
  input  logic                              slow_adc_rst,
  input  logic                              resp_rqst_i,
  input  radio_ctrl_pkg::cmd_resp_t         pending_i,
  output logic                              taken_o,
  input  radio_ctrl_pkg::adc_readings_t     adc_i,
  input  logic                              ptt_i,
  input  logic                              rxclip_i,
  input  logic [7:0]                        dsiq_status_i,
  output logic [radio_ctrl_pkg::RESP_W-1:0] resp_o,
  output logic                              dsiq_sample_o
);

  radio_ctrl_pkg::resp_slot_e slot;
  logic                       parity;
  logic [1:0]                 clip_cnt;
  logic                       clip_flag;
  logic                       ptt_q;
  logic [31:0]                status_payload;

  assign clip_flag = &clip_cnt;

  // Command responses only go out on even requests
  assign taken_o = resp_rqst_i & pending_i.valid & ~parity;

  always_comb begin
    case (slot)
      radio_ctrl_pkg::SLOT_STATUS: begin
        status_payload = {7'b0001111, clip_flag, 8'h00, dsiq_status_i, VERSION_MAJOR};
      end
      radio_ctrl_pkg::SLOT_TEMP_FWD: begin
        status_payload = {4'h0, adc_i.temperature, 4'h0, adc_i.fwd_pwr};
      end
      radio_ctrl_pkg::SLOT_REV_BIAS: begin
        status_payload = {4'h0, adc_i.rev_pwr, 4'h0, adc_i.bias_current};
      end
      radio_ctrl_pkg::SLOT_SPARE: status_payload = 32'h0;
      default:                    status_payload = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      ptt_q <= 1'b0;
    end else begin
      ptt_q <= ptt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      parity   <= 1'b0;
      slot     <= radio_ctrl_pkg::SLOT_STATUS;
      clip_cnt <= 2'd0;
      resp_o   <= {8'h00, 8'h1E, 16'h0000, VERSION_MAJOR};
    end else if (resp_rqst_i) begin
      parity   <= ~parity;
      // A slot is skipped when a command response takes its place
      slot     <= radio_ctrl_pkg::resp_slot_e'(slot + 2'd1);
      clip_cnt <= 2'd0;
      if (taken_o) begin
        resp_o <= {1'b1, pending_i.addr, ptt_q, pending_i.data};
      end else begin
        resp_o <= {3'b000, slot, 1'b0, 1'b0, ptt_q, status_payload};
      end
    end else if (!clip_flag) begin
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  // Slow ADC sample strobe, once per slot rotation
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      dsiq_sample_o <= 1'b0;
    end else if (resp_rqst_i && (slot == radio_ctrl_pkg::SLOT_TEMP_FWD)) begin
      dsiq_sample_o <= ~dsiq_sample_o;
    end
  end

endmodule

//--- rtl/cmd_resp_fsm.sv
`timescale 1ns/1ns

module cmd_resp_fsm (
  input  logic                      clk,
  input  logic                      slow_adc_rst,
  input  radio_ctrl_pkg::cmd_t      cmd_i,
  input  radio_ctrl_pkg::sub_resp_t sub_resp_i,
  input  logic                      taken_i,
  output radio_ctrl_pkg::cmd_resp_t pending_o
);

  radio_ctrl_pkg::resp_state_e resp_state;
  radio_ctrl_pkg::resp_state_e resp_state_next;
  logic [5:0]                  resp_addr;
  logic [5:0]                  resp_addr_next;
  logic [31:0]                 resp_data;
  logic [31:0]                 resp_data_next;
  logic                        new_cmd;

  assign new_cmd = cmd_i.rqst & cmd_i.requires_resp;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      resp_state <= radio_ctrl_pkg::RESP_START;
    end else begin
      resp_state <= resp_state_next;
    end
  end

  always_ff @(posedge clk) begin
    resp_addr <= resp_addr_next;
    resp_data <= resp_data_next;
  end

  always_comb begin
    resp_state_next = resp_state;
    resp_addr_next  = resp_addr;
    resp_data_next  = resp_data;
    case (resp_state)
      radio_ctrl_pkg::RESP_START: begin
        if (new_cmd) begin
          resp_addr_next  = cmd_i.addr;
          resp_data_next  = cmd_i.data;
          resp_state_next = radio_ctrl_pkg::RESP_ACK;
        end
      end
      radio_ctrl_pkg::RESP_ACK: begin
        // Subsystem busy, answer with an error but keep the data
        if (!sub_resp_i.ack) begin
          resp_addr_next  = radio_ctrl_pkg::CMD_ERROR;
          resp_state_next = radio_ctrl_pkg::RESP_WAIT;
        end else begin
          resp_state_next = radio_ctrl_pkg::RESP_READ;
        end
      end
      radio_ctrl_pkg::RESP_READ: begin
        // ack stays low while a read is in flight
        if (!sub_resp_i.ack) begin
          resp_data_next = sub_resp_i.rdata;
        end else begin
          resp_state_next = radio_ctrl_pkg::RESP_WAIT;
        end
      end
      radio_ctrl_pkg::RESP_WAIT: begin
        if (taken_i) begin
          if (new_cmd) begin
            resp_addr_next  = cmd_i.addr;
            resp_data_next  = cmd_i.data;
            resp_state_next = radio_ctrl_pkg::RESP_ACK;
          end else begin
            resp_state_next = radio_ctrl_pkg::RESP_START;
          end
        end
      end
      default: resp_state_next = radio_ctrl_pkg::RESP_START;
    endcase
  end

  assign pending_o.valid = (resp_state == radio_ctrl_pkg::RESP_WAIT);
  assign pending_o.addr  = resp_addr;
  assign pending_o.data  = resp_data;

endmodule

//--- rtl/fan_ctrl.sv
`timescale 1ns/1ns

module fan_ctrl #(
  parameter int FAN_CNT_W = 16
) (
  input  logic                             clk,
  input  logic                             slow_adc_rst,
  input  logic [radio_ctrl_pkg::ADC_W-1:0] temperature_i,
  output logic                             fan_pwm_o,
  output logic                             tx_enable_o
);

  radio_ctrl_pkg::fan_state_e fan_state;
  radio_ctrl_pkg::fan_state_e fan_state_next;
  logic [FAN_CNT_W-1:0]       fan_cnt;

  // Free-running duty counter
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      fan_cnt <= '0;
    end else begin
      fan_cnt <= fan_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      fan_state <= radio_ctrl_pkg::FAN_OFF;
    end else begin
      fan_state <= fan_state_next;
    end
  end

  // Hysteresis ladder, one step per cycle at most
  always_comb begin
    fan_state_next = fan_state;
    case (fan_state)
      radio_ctrl_pkg::FAN_OFF: begin
        if (temperature_i > radio_ctrl_pkg::TEMP_35C) begin
          fan_state_next = radio_ctrl_pkg::FAN_LOWSPEED;
        end
      end
      radio_ctrl_pkg::FAN_LOWSPEED: begin
        if (temperature_i > radio_ctrl_pkg::TEMP_40C) begin
          fan_state_next = radio_ctrl_pkg::FAN_MEDSPEED;
        end else if (temperature_i < radio_ctrl_pkg::TEMP_30C) begin
          fan_state_next = radio_ctrl_pkg::FAN_OFF;
        end
      end
      radio_ctrl_pkg::FAN_MEDSPEED: begin
        if (temperature_i > radio_ctrl_pkg::TEMP_45C) begin
          fan_state_next = radio_ctrl_pkg::FAN_FULLSPEED;
        end else if (temperature_i < radio_ctrl_pkg::TEMP_35C) begin
          fan_state_next = radio_ctrl_pkg::FAN_LOWSPEED;
        end
      end
      radio_ctrl_pkg::FAN_FULLSPEED: begin
        if (temperature_i > radio_ctrl_pkg::TEMP_55C) begin
          fan_state_next = radio_ctrl_pkg::FAN_OVERHEAT;
        end else if (temperature_i < radio_ctrl_pkg::TEMP_40C) begin
          fan_state_next = radio_ctrl_pkg::FAN_MEDSPEED;
        end
      end
      radio_ctrl_pkg::FAN_OVERHEAT: begin
        if (temperature_i < radio_ctrl_pkg::TEMP_50C) begin
          fan_state_next = radio_ctrl_pkg::FAN_FULLSPEED;
        end
      end
      default: fan_state_next = radio_ctrl_pkg::FAN_OFF;
    endcase
  end

  always_comb begin
    case (fan_state)
      radio_ctrl_pkg::FAN_LOWSPEED:  fan_pwm_o = fan_cnt[FAN_CNT_W-1];
      // Top two bits give three quarters on
      radio_ctrl_pkg::FAN_MEDSPEED:  fan_pwm_o = fan_cnt[FAN_CNT_W-1] | fan_cnt[FAN_CNT_W-2];
      radio_ctrl_pkg::FAN_FULLSPEED: fan_pwm_o = 1'b1;
      radio_ctrl_pkg::FAN_OVERHEAT:  fan_pwm_o = 1'b1;
      default:                       fan_pwm_o = 1'b0;
    endcase
  end

  assign tx_enable_o = (fan_state != radio_ctrl_pkg::FAN_OVERHEAT);

endmodule

//--- rtl/tx_keying.sv
`timescale 1ns/1ns

module tx_keying (
  input  logic                     clk,
  input  logic                     slow_adc_rst,
  input  radio_ctrl_pkg::cmd_t     cmd_i,
  input  logic                     tx_on_i,
  input  logic                     run_i,
  input  logic                     ptt_i,
  input  logic                     inhibit_i,
  input  logic                     temp_tx_enable_i,
  output radio_ctrl_pkg::pa_ctrl_t pa_o
);

  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic tx_active;

  // Transmit control register
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
    end else if (cmd_i.rqst && (cmd_i.addr == radio_ctrl_pkg::CMD_TX_CTRL)) begin
      vna        <= cmd_i.data[23];
      pa_enable  <= cmd_i.data[19];
      tr_disable <= cmd_i.data[18];
    end
  end

  // Host or front-panel request, gated by every inhibit source
  assign tx_active = (tx_on_i | ptt_i) & ~inhibit_i & run_i & temp_tx_enable_i;

  always_comb begin
    pa_o.envop    = tx_active;
    pa_o.exttr    = tx_active;
    pa_o.envbias  = tx_active & ~vna & pa_enable;
    pa_o.envpa    = tx_active & ~vna & pa_enable;
    // Internal T/R relay still switches without the PA unless disabled
    pa_o.inttr    = tx_active & ~vna & (pa_enable | ~tr_disable);
    pa_o.rfsw_sel = ~vna & pa_enable;
  end

endmodule

//--- rtl/debounce.sv
`timescale 1ns/1ns

module debounce #(
  parameter int DEBOUNCE_CYCLES = 16250
) (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic pin_n_i,
  output logic level_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic             pin_level;
  logic [CNT_W-1:0] stable_cnt;

  // Pins are active low at the connector
  assign pin_level = ~pin_n_i;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      stable_cnt <= '0;
      level_o    <= 1'b0;
    end else if (pin_level == level_o) begin
      // Any bounce back restarts the count
      stable_cnt <= '0;
    end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
      stable_cnt <= '0;
      level_o    <= pin_level;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

//--- rtl/tick_gen.sv
`timescale 1ns/1ns

module tick_gen #(
  parameter int QMSEC_RELOAD = 625
) (
  input  logic clk,
  input  logic slow_adc_rst,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  localparam int CNT_W = $clog2(QMSEC_RELOAD + 1);

  logic [CNT_W-1:0] qmsec_cnt;
  logic [1:0]       msec_cnt;
  logic             qmsec_wrap;

  assign qmsec_wrap = (qmsec_cnt == '0);

  // Down-counter, one pulse per reload
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      qmsec_cnt     <= CNT_W'(QMSEC_RELOAD);
      qmsec_pulse_o <= 1'b0;
    end else if (qmsec_wrap) begin
      qmsec_cnt     <= CNT_W'(QMSEC_RELOAD);
      qmsec_pulse_o <= 1'b1;
    end else begin
      qmsec_cnt     <= qmsec_cnt - 1'b1;
      qmsec_pulse_o <= 1'b0;
    end
  end

  // Every fourth quarter tick, first one included in the count
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      msec_cnt     <= 2'd0;
      msec_pulse_o <= 1'b0;
    end else begin
      msec_pulse_o <= qmsec_wrap & (&msec_cnt);
      if (qmsec_wrap) begin
        msec_cnt <= msec_cnt + 2'd1;
      end
    end
  end

endmodule

//--- rtl/radio_ctrl_pkg.sv
package radio_ctrl_pkg;

  localparam int ADC_W  = 12;
  localparam int RESP_W = 40;

  // Fan thresholds as slow-ADC codes of the thermistor channel
  localparam logic [ADC_W-1:0] TEMP_30C = 12'b001111101101;
  localparam logic [ADC_W-1:0] TEMP_35C = 12'b010000101011;
  localparam logic [ADC_W-1:0] TEMP_40C = 12'b010001101011;
  localparam logic [ADC_W-1:0] TEMP_45C = 12'b010010101010;
  localparam logic [ADC_W-1:0] TEMP_50C = 12'b010011101000;
  localparam logic [ADC_W-1:0] TEMP_55C = 12'b010100100111;

  typedef enum logic [5:0] {
    CMD_TX_CTRL = 6'h09,
    CMD_ERROR   = 6'h3F
  } cmd_addr_e;

  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        rqst;
    logic        requires_resp;
  } cmd_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } sub_resp_t;

  typedef struct packed {
    logic [ADC_W-1:0] fwd_pwr;
    logic [ADC_W-1:0] rev_pwr;
    logic [ADC_W-1:0] bias_current;
    logic [ADC_W-1:0] temperature;
  } adc_readings_t;

  typedef struct packed {
    logic envbias;
    logic envop;
    logic exttr;
    logic inttr;
    logic envpa;
    logic rfsw_sel;
  } pa_ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [5:0]  addr;
    logic [31:0] data;
  } cmd_resp_t;

  // Gray-coded along the START to ACK to READ to WAIT read sequence
  typedef enum logic [1:0] {
    RESP_START = 2'b00,
    RESP_ACK   = 2'b01,
    RESP_READ  = 2'b11,
    RESP_WAIT  = 2'b10
  } resp_state_e;

  typedef enum logic [2:0] {
    FAN_OFF       = 3'b000,
    FAN_LOWSPEED  = 3'b001,
    FAN_MEDSPEED  = 3'b011,
    FAN_FULLSPEED = 3'b010,
    FAN_OVERHEAT  = 3'b110
  } fan_state_e;

  typedef enum logic [1:0] {
    SLOT_STATUS   = 2'd0,
    SLOT_TEMP_FWD = 2'd1,
    SLOT_REV_BIAS = 2'd2,
    SLOT_SPARE    = 2'd3
  } resp_slot_e;

endpackage
